// ==== verification/sprite_tests.txt ====
# Columns: command letter, then fields. w addr data (hex), a dmaActive mask (hex),
# l sprite (dec) byte (hex), r startX count (dec) then p run valid sprite color (dec),
# c expected collision mask (hex), x pulses collisionClear
# Hires sprite 0 at x 100 in color 7
w 0 64
w c 07
w 9 01
a 01
l 0 a5
l 0 f0
l 0 0f
r 98 28
p 2 0 0 0
p 1 1 0 7
p 1 0 0 0
p 1 1 0 7
p 2 0 0 0
p 1 1 0 7
p 1 0 0 0
p 5 1 0 7
p 8 0 0 0
p 4 1 0 7
p 2 0 0 0
c 00
# Sprite 1 at x 300 with X expansion
w 1 2c
w 8 02
w c 15
w a 02
w 9 02
a 02
l 1 f0
l 1 0f
l 1 81
r 300 50
p 8 1 1 5
p 16 0 0 0
p 10 1 1 5
p 12 0 0 0
p 2 1 1 5
p 2 0 0 0
# Multicolor sprite 2 at x 40 with mc0 3, color 9 and mc1 12
w 2 28
w 8 00
w a 00
w b 04
w c 29
w d 03
w e 0c
w 9 04
a 04
l 2 1b
l 2 e4
l 2 00
r 40 26
p 2 0 0 0
p 2 1 2 3
p 2 1 2 9
p 4 1 2 12
p 2 1 2 9
p 2 1 2 3
p 12 0 0 0
# Same sprite with X expansion, four pixels per code
w a 04
l 2 6c
l 2 00
l 2 c0
r 40 48
p 4 1 2 3
p 4 1 2 9
p 4 1 2 12
p 20 0 0 0
p 4 1 2 12
p 12 0 0 0
# Sprites 3 and 5 overlap, sprite 3 wins where it is opaque
w b 00
w a 00
w 3 c8
w 5 cc
w c 31
w c 52
w 9 28
a 28
l 3 ff
l 3 00
l 3 ff
l 5 ff
l 5 ff
l 5 ff
r 200 28
p 8 1 3 1
p 8 1 5 2
p 8 1 3 1
p 4 1 5 2
c 28
x
c 00
# Sprite 3 loads are dropped while its dmaActive bit is low
a 20
l 3 ff
l 3 ff
l 3 ff
l 5 0f
l 5 ff
l 5 f0
a 28
r 200 28
p 8 0 0 0
p 16 1 5 2
p 4 0 0 0
c 00

// ==== verilog.f ====
+incdir+design
design/sprite_pkg.sv
design/spriteCtrlIf.sv
design/spriteSequencer.sv
design/spritePixelShifter.sv
design/spriteColorMux.sv
design/spriteUnit.sv
verification/spriteUnit_checker.sv
verification/spriteUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and searches the log for the pass line
set -e

verilator --binary --timing --assert -j 0 --top-module spriteUnitTb -f verilog.f -o spriteSim

# tee keeps the pipeline alive so the log is always searched
./obj_dir/spriteSim 2>&1 | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// ==== verification/spriteUnitTb.sv ====
`timescale 1ns/10ps

module spriteUnitTb;
	import spritePkg::*;

	// ==================================================
	// DUT signals
	// ==================================================

	logic clk33;
	logic arstN;
	logic clken8;
	logic regWe;
	logic [3:0] regAddr;
	logic [7:0] regData;
	xPosT rasterX;
	spriteMaskT dmaActive;
	vicCycleT vicCycle;
	logic enaData;
	spriteIdT spriteNum;
	logic [7:0] db;
	logic collisionClear;
	logic pixelValid;
	colorT pixelColor;
	spriteIdT pixelSprite;
	spriteMaskT collision;

	// Position inside the four cycle frame of the pixel tick
	int tickPhase;
	int cycleCnt;
	int cycleLimit;

	// Expected pixels of the raster line that is running
	logic expValid [$];
	spriteIdT expSprite [$];
	colorT expColor [$];

	spriteUnit dut_i (
		.clk33(clk33),
		.arstN(arstN),
		.clken8(clken8),
		.regWe(regWe),
		.regAddr(regAddr),
		.regData(regData),
		.rasterX(rasterX),
		.dmaActive(dmaActive),
		.vicCycle(vicCycle),
		.enaData(enaData),
		.spriteNum(spriteNum),
		.db(db),
		.collisionClear(collisionClear),
		.pixelValid(pixelValid),
		.pixelColor(pixelColor),
		.pixelSprite(pixelSprite),
		.collision(collision)
	);

	initial begin
		clk33 = 1'b0;
		forever #10 clk33 = ~clk33;
	end

	// Watchdog, the limit is set once the test file has been counted
	initial begin
		cycleCnt = 0;
		forever begin
			@(posedge clk33);
			cycleCnt++;
			if (cycleCnt > cycleLimit)
				failRun($sformatf("Timeout after %0d cycles, the tests did not finish", cycleCnt));
		end
	end

	// ==================================================
	// Reporting
	// ==================================================

	task automatic failRun(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic checkValue(input string name, input int got, input int want);
		assert (got == want) else
			failRun($sformatf("MISMATCH time=%0t signal=%s got=%0h expected=%0h",
				$time, name, got, want));
	endtask

	// Color and winner only mean something on a valid pixel
	task automatic checkPixel(input int x, input logic v, input spriteIdT s, input colorT c);
		checkValue($sformatf("pixelValid at x %0d", x), int'(pixelValid), int'(v));
		if (v) begin
			checkValue($sformatf("pixelSprite at x %0d", x), int'(pixelSprite), int'(s));
			checkValue($sformatf("pixelColor at x %0d", x), int'(pixelColor), int'(c));
		end
	endtask

	// ==================================================
	// Bus drivers, all on the falling edge
	// ==================================================

	// Every call moves one cycle on and drops the strobes back to idle
	task automatic advance();
		@(negedge clk33);
		tickPhase = (tickPhase + 1) % 4;
		clken8 = (tickPhase == 0);
		regWe = 1'b0;
		enaData = 1'b0;
		vicCycle = VIC_IDLE;
		collisionClear = 1'b0;
	endtask

	task automatic writeReg(input logic [3:0] addr, input logic [7:0] data);
		advance();
		regWe = 1'b1;
		regAddr = addr;
		regData = data;
	endtask

	task automatic loadByte(input spriteIdT num, input logic [7:0] data);
		advance();
		vicCycle = VIC_SPRITE;
		enaData = 1'b1;
		spriteNum = num;
		db = data;
	endtask

	// Pixel x leaves the color stage three ticks after rasterX was x,
	// so the check at tick i looks at the pixel of tick i minus 4
	task automatic runRaster(input int startX, input int count);
		int p;
		advance();
		while (!clken8)
			advance();
		for (int i = 0; i <= count + 3; i++) begin
			p = i - 4;
			if (p >= 0)
				checkPixel(startX + p, expValid[p], expSprite[p], expColor[p]);
			rasterX = xPosT'(startX + i);
			repeat (4) advance();
		end
		// Park the raster where no sprite sits and let the pipeline drain
		rasterX = 9'h1ff;
		repeat (16) advance();
	endtask

	// ==================================================
	// Test file reader
	// ==================================================

	// Skips comment lines and blank lines
	task automatic nextLine(input int fd, output string line, output bit found);
		int rc;
		found = 1'b0;
		while (!found && !$feof(fd)) begin
			line = "";
			rc = $fgets(line, fd);
			if (rc > 0 && line.len() > 0 && line.getc(0) != "#" && line.getc(0) != "\n")
				found = 1'b1;
		end
	endtask

	function automatic string fieldsOf(input string line);
		return line.substr(1, line.len() - 1);
	endfunction

	task automatic expectFields(input int got, input int want, input string line);
		if (got != want)
			failRun({"Malformed line in the test file: ", line});
	endtask

	task automatic countTests(input int fd, output int cmds, output int lines,
		output int pixels);
		string line;
		bit found;
		int x;
		int n;
		cmds = 0;
		lines = 0;
		pixels = 0;
		nextLine(fd, line, found);
		while (found) begin
			cmds++;
			if (line.getc(0) == "r" && $sscanf(fieldsOf(line), "%d %d", x, n) == 2) begin
				lines++;
				pixels += n;
			end
			nextLine(fd, line, found);
		end
	endtask

	task automatic runTests(input int fd);
		string line;
		bit found;
		byte cmd;
		int a;
		int b;
		int n;
		int v;
		int s;
		int col;
		int got;
		nextLine(fd, line, found);
		while (found) begin
			cmd = line.getc(0);
			case (cmd)
				"w": begin
					got = $sscanf(fieldsOf(line), "%h %h", a, b);
					expectFields(got, 2, line);
					writeReg(4'(a), 8'(b));
				end
				"a": begin
					got = $sscanf(fieldsOf(line), "%h", a);
					expectFields(got, 1, line);
					advance();
					dmaActive = spriteMaskT'(a);
				end
				"l": begin
					got = $sscanf(fieldsOf(line), "%d %h", a, b);
					expectFields(got, 2, line);
					loadByte(spriteIdT'(a), 8'(b));
				end
				"r": begin
					got = $sscanf(fieldsOf(line), "%d %d", a, b);
					expectFields(got, 2, line);
					expValid.delete();
					expSprite.delete();
					expColor.delete();
					// Pixel runs follow their raster line directly
					while (expValid.size() < b) begin
						nextLine(fd, line, found);
						if (!found || line.getc(0) != "p")
							failRun("A raster line in the test file lacks its pixel runs");
						got = $sscanf(fieldsOf(line), "%d %d %d %d", n, v, s, col);
						expectFields(got, 4, line);
						for (int k = 0; k < n; k++) begin
							expValid.push_back(v != 0);
							expSprite.push_back(spriteIdT'(s));
							expColor.push_back(colorT'(col));
						end
					end
					if (expValid.size() != b)
						failRun("Pixel runs in the test file overrun their raster line");
					runRaster(a, b);
				end
				"c": begin
					got = $sscanf(fieldsOf(line), "%h", a);
					expectFields(got, 1, line);
					advance();
					checkValue("collision", int'(collision), a);
				end
				"x": begin
					advance();
					collisionClear = 1'b1;
				end
				default: failRun({"Unknown command in the test file: ", line});
			endcase
			nextLine(fd, line, found);
		end
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin
		int fd;
		int cmdCount;
		int lineCount;
		int pixelCount;
		arstN = 1'b0;
		clken8 = 1'b0;
		regWe = 1'b0;
		regAddr = '0;
		regData = '0;
		rasterX = 9'h1ff;
		dmaActive = '0;
		vicCycle = VIC_IDLE;
		enaData = 1'b0;
		spriteNum = '0;
		db = '0;
		collisionClear = 1'b0;
		tickPhase = 0;
		cycleLimit = 1000;
		// First pass only sizes the timeout
		fd = $fopen("verification/sprite_tests.txt", "r");
		if (fd == 0)
			failRun("Cannot open the test file verification/sprite_tests.txt");
		countTests(fd, cmdCount, lineCount, pixelCount);
		$fclose(fd);
		cycleLimit = 64 + 8 * cmdCount + 4 * pixelCount + 48 * lineCount;
		repeat (8) @(negedge clk33);
		arstN = 1'b1;
		fd = $fopen("verification/sprite_tests.txt", "r");
		runTests(fd);
		$fclose(fd);
		repeat (8) advance();
		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== verification/spriteUnit_checker.sv ====
`timescale 1ns/10ps

// Concurrent checks on the shift control of the sprite pixel path
module spriteUnitChecker (
	input logic                  clk33,
	input logic                  arstN,
	input spritePkg::spriteMaskT shift,
	input spritePkg::spriteMaskT clkShift,
	input spritePkg::spriteMaskT dmaActive,
	input logic                  pixelValid
);

	// Nothing shifts or shows while reset is held
	resetQuiet: assert property (@(posedge clk33) !arstN |-> (shift == '0) && !pixelValid)
		else $error("shift or pixelValid is active during reset");

	// A shift clock only ever lands inside the display window
	clkShiftInWindow: assert property (@(posedge clk33) disable iff (!arstN)
		(clkShift & ~shift) == '0)
		else $error("clkShift is set outside the shift window");

	// The window opens from values sampled one edge earlier,
	// so the rise is compared with the previous dmaActive
	shiftNeedsDma: assert property (@(posedge clk33) disable iff (!arstN)
		(shift & ~$past(shift) & ~$past(dmaActive)) == '0)
		else $error("A shift window opened for a sprite without dmaActive");

endmodule

bind spriteUnit spriteUnitChecker chk_i (
	.clk33(clk33),
	.arstN(arstN),
	.shift(ctrlBus.shift),
	.clkShift(ctrlBus.clkShift),
	.dmaActive(dmaActive),
	.pixelValid(pixelValid)
);

// ==== design/spriteUnit.sv ====
`timescale 1ns/10ps
`include "sprite_params.svh"

module spriteUnit (
	input  logic                   clk33,
	input  logic                   arstN,
	input  logic                   clken8,
	input  logic                   regWe,
	input  logic [3:0]             regAddr,
	input  logic [7:0]             regData,
	input  spritePkg::xPosT        rasterX,
	input  spritePkg::spriteMaskT  dmaActive,
	input  spritePkg::vicCycleT    vicCycle,
	input  logic                   enaData,
	input  spritePkg::spriteIdT    spriteNum,
	input  logic [7:0]             db,
	input  logic                   collisionClear,
	output logic                   pixelValid,
	output spritePkg::colorT       pixelColor,
	output spritePkg::spriteIdT    pixelSprite,
	output spritePkg::spriteMaskT  collision
);
	import spritePkg::*;

	// Shift control bundle between sequencer and shifter
	spriteCtrlIf ctrlBus ();

	// Sprite colors from the register file
	colorT spriteColor [`SPRITE_COUNT];
	colorT mc0;
	colorT mc1;

	// Delayed pixel codes, one per sprite
	pixelCodeT currentPixel [`SPRITE_COUNT];

	// ================================================
	// Pixel path, sequencer to shifter to color stage
	// ================================================

	spriteSequencer uSeq (
		.clk33(clk33),
		.arstN(arstN),
		.clken8(clken8),
		.regWe(regWe),
		.regAddr(regAddr),
		.regData(regData),
		.rasterX(rasterX),
		.dmaActive(dmaActive),
		.spriteColor(spriteColor),
		.mc0(mc0),
		.mc1(mc1),
		.ctrl(ctrlBus.seq)
	);

	spritePixelShifter uShifter (
		.clk33(clk33),
		.arstN(arstN),
		.clken8(clken8),
		.vicCycle(vicCycle),
		.enaData(enaData),
		.spriteNum(spriteNum),
		.db(db),
		.ctrl(ctrlBus.shifter),
		.currentPixel(currentPixel)
	);

	// The color stage needs the mode bits too, taken straight off the bundle
	spriteColorMux uColor (
		.clk33(clk33),
		.arstN(arstN),
		.clken8(clken8),
		.currentPixel(currentPixel),
		.multicolor(ctrlBus.multicolor),
		.spriteColor(spriteColor),
		.mc0(mc0),
		.mc1(mc1),
		.collisionClear(collisionClear),
		.pixelValid(pixelValid),
		.pixelColor(pixelColor),
		.pixelSprite(pixelSprite),
		.collision(collision)
	);

endmodule

// ==== design/spriteColorMux.sv ====
`timescale 1ns/10ps
`include "sprite_params.svh"

module spriteColorMux (
	input  logic                   clk33,
	input  logic                   arstN,
	input  logic                   clken8,
	input  spritePkg::pixelCodeT   currentPixel [`SPRITE_COUNT],
	input  spritePkg::spriteMaskT  multicolor,
	input  spritePkg::colorT       spriteColor [`SPRITE_COUNT],
	input  spritePkg::colorT       mc0,
	input  spritePkg::colorT       mc1,
	input  logic                   collisionClear,
	output logic                   pixelValid,
	output spritePkg::colorT       pixelColor,
	output spritePkg::spriteIdT    pixelSprite,
	output spritePkg::spriteMaskT  collision
);
	import spritePkg::*;

	// ================================================
	// Code to color mapping
	// ================================================

	spriteMaskT opaque;
	colorT codeColor [`SPRITE_COUNT];

	always_comb begin
		for (int n = 0; n < `SPRITE_COUNT; n++) begin
			if (multicolor[n]) begin
				// Every nonzero code is drawn in multicolor mode
				opaque[n] = (currentPixel[n] != 2'b00);
				case (currentPixel[n])
					2'b01: codeColor[n] = mc0;
					2'b10: codeColor[n] = spriteColor[n];
					default: codeColor[n] = mc1;
				endcase
			end else begin
				// Hires pixel lives in the top bit only
				opaque[n] = currentPixel[n][1];
				codeColor[n] = spriteColor[n];
			end
		end
	end

	// ================================================
	// Priority and collision detect
	// ================================================

	spriteIdT winId;
	colorT winColor;
	logic multiHit;

	// Walk from the highest index down so the lowest opaque sprite wins
	always_comb begin
		winId = '0;
		winColor = '0;
		for (int n = `SPRITE_COUNT - 1; n >= 0; n--) begin
			if (opaque[n]) begin
				winId = spriteIdT'(n);
				winColor = codeColor[n];
			end
		end
	end

	// More than one bit set means at least two sprites overlap
	assign multiHit = (opaque & (opaque - spriteMaskT'(1))) != '0;

	always_ff @(posedge clk33 or negedge arstN) begin
		if (!arstN) begin
			pixelValid <= 1'b0;
			pixelColor <= '0;
			pixelSprite <= '0;
		end else if (clken8) begin
			pixelValid <= |opaque;
			pixelColor <= winColor;
			pixelSprite <= winId;
		end
	end

	// Collision bits are sticky until software clears them
	always_ff @(posedge clk33 or negedge arstN) begin
		if (!arstN)
			collision <= '0;
		else if (collisionClear)
			collision <= '0;
		else if (clken8 && multiHit)
			collision <= collision | opaque;
	end

endmodule

// ==== design/spritePixelShifter.sv ====
`timescale 1ns/10ps
`include "sprite_params.svh"

module spritePixelShifter (
	input  logic                  clk33,
	input  logic                  arstN,
	input  logic                  clken8,
	input  spritePkg::vicCycleT   vicCycle,
	input  logic                  enaData,
	input  spritePkg::spriteIdT   spriteNum,
	input  logic [7:0]            db,
	spriteCtrlIf.shifter          ctrl,
	output spritePkg::pixelCodeT  currentPixel [`SPRITE_COUNT]
);
	import spritePkg::*;

	// ================================================
	// Sprite data shift registers
	// ================================================

	logic [`SPRITE_BITS-1:0] pixData [`SPRITE_COUNT];
	logic loadHit;

	// A byte is taken in any sprite fetch cycle with valid bus data,
	// provided the addressed sprite is live on this line
	assign loadHit = (vicCycle == VIC_SPRITE) && enaData && ctrl.active[spriteNum];

	always_ff @(posedge clk33 or negedge arstN) begin
		if (!arstN) begin
			for (int n = 0; n < `SPRITE_COUNT; n++) begin
				pixData[n] <= '0;
			end
		end else begin
			for (int n = 0; n < `SPRITE_COUNT; n++) begin
				if (loadHit && (spriteNum == spriteIdT'(n))) begin
					// Fetched bytes enter at the bottom, three fill the register
					pixData[n] <= {pixData[n][`SPRITE_BITS-9:0], db};
				end else if (clken8 && ctrl.clkShift[n]) begin
					// Multicolor moves a whole 2-bit code per shift
					if (ctrl.multicolor[n])
						pixData[n] <= {pixData[n][`SPRITE_BITS-3:0], 2'b00};
					else
						pixData[n] <= {pixData[n][`SPRITE_BITS-2:0], 1'b0};
				end
			end
		end
	end

	// ================================================
	// Current pixel stage
	// ================================================

	// The top two bits are sampled before this tick's shift takes effect
	// Outside the window the code is forced transparent
	always_ff @(posedge clk33 or negedge arstN) begin
		if (!arstN) begin
			for (int n = 0; n < `SPRITE_COUNT; n++) begin
				currentPixel[n] <= '0;
			end
		end else if (clken8) begin
			for (int n = 0; n < `SPRITE_COUNT; n++) begin
				if (ctrl.shift[n])
					currentPixel[n] <= pixData[n][`SPRITE_BITS-1:`SPRITE_BITS-2];
				else
					currentPixel[n] <= 2'b00;
			end
		end
	end

endmodule

// ==== design/spriteSequencer.sv ====
`timescale 1ns/10ps
`include "sprite_params.svh"

module spriteSequencer (
	input  logic                clk33,
	input  logic                arstN,
	input  logic                clken8,
	input  logic                regWe,
	input  logic [3:0]          regAddr,
	input  logic [7:0]          regData,
	input  spritePkg::xPosT     rasterX,
	input  spritePkg::spriteMaskT dmaActive,
	output spritePkg::colorT    spriteColor [`SPRITE_COUNT],
	output spritePkg::colorT    mc0,
	output spritePkg::colorT    mc1,
	spriteCtrlIf.seq            ctrl
);
	import spritePkg::*;

	// ================================================
	// Sprite registers
	// ================================================

	logic [7:0] xLow [`SPRITE_COUNT];
	spriteMaskT xMsb;
	spriteMaskT enable;
	spriteMaskT expand;
	spriteMaskT mcMode;
	xPosT xPos [`SPRITE_COUNT];

	// Writes land on the next clock edge, no pixel tick needed
	always_ff @(posedge clk33 or negedge arstN) begin
		if (!arstN) begin
			for (int n = 0; n < `SPRITE_COUNT; n++) begin
				xLow[n] <= '0;
				spriteColor[n] <= '0;
			end
			xMsb <= '0;
			enable <= '0;
			expand <= '0;
			mcMode <= '0;
			mc0 <= '0;
			mc1 <= '0;
		end else if (regWe) begin
			// The low half of the map is the X low byte of each sprite
			if (!regAddr[3]) begin
				xLow[regAddr[2:0]] <= regData;
			end else begin
				case (regAddr)
					`SPRITE_REG_XMSB: xMsb <= regData;
					`SPRITE_REG_ENABLE: enable <= regData;
					`SPRITE_REG_EXPAND: expand <= regData;
					`SPRITE_REG_MCMODE: mcMode <= regData;
					`SPRITE_REG_COLOR: spriteColor[regData[6:4]] <= regData[3:0];
					`SPRITE_REG_MC0: mc0 <= regData[3:0];
					`SPRITE_REG_MC1: mc1 <= regData[3:0];
					default: ;
				endcase
			end
		end
	end

	// Full nine bit X position per sprite
	always_comb begin
		for (int n = 0; n < `SPRITE_COUNT; n++) begin
			xPos[n] = {xMsb[n], xLow[n]};
		end
	end

	// ================================================
	// X compare and display window
	// ================================================

	// matchQ holds the compare result of the previous tick
	spriteMaskT matchQ;
	spriteMaskT shiftQ;
	logic [5:0] pixelCnt [`SPRITE_COUNT];
	logic [1:0] phase [`SPRITE_COUNT];

	always_ff @(posedge clk33 or negedge arstN) begin
		if (!arstN) begin
			matchQ <= '0;
			shiftQ <= '0;
			for (int n = 0; n < `SPRITE_COUNT; n++) begin
				pixelCnt[n] <= '0;
				phase[n] <= '0;
			end
		end else if (clken8) begin
			for (int n = 0; n < `SPRITE_COUNT; n++) begin
				matchQ[n] <= (rasterX == xPos[n]) && enable[n] && dmaActive[n];
				if (shiftQ[n]) begin
					// Phase counts ticks inside the window and paces clkShift
					phase[n] <= phase[n] + 2'd1;
					if (pixelCnt[n] == '0)
						shiftQ[n] <= 1'b0;
					else
						pixelCnt[n] <= pixelCnt[n] - 6'd1;
				end else if (matchQ[n] && enable[n] && dmaActive[n]) begin
					// Open a window of 24 ticks, doubled when X expanded
					shiftQ[n] <= 1'b1;
					phase[n] <= 2'd0;
					pixelCnt[n] <= expand[n] ? 6'(2 * `SPRITE_BITS - 1)
						: 6'(`SPRITE_BITS - 1);
				end
			end
		end
	end

	// ================================================
	// Shift rate
	// ================================================

	// Hires plain shifts each tick, hires expanded and multicolor every
	// second tick, multicolor expanded every fourth tick
	spriteMaskT rateTick;

	always_comb begin
		for (int n = 0; n < `SPRITE_COUNT; n++) begin
			case ({mcMode[n], expand[n]})
				2'b00: rateTick[n] = 1'b1;
				2'b11: rateTick[n] = &phase[n];
				default: rateTick[n] = phase[n][0];
			endcase
		end
	end

	assign ctrl.active = dmaActive;
	assign ctrl.multicolor = mcMode;
	assign ctrl.shift = shiftQ;
	assign ctrl.clkShift = shiftQ & rateTick;

endmodule

// ==== design/spriteCtrlIf.sv ====
`timescale 1ns/10ps

// Per-sprite shift control from the sequencer to the pixel shifter
interface spriteCtrlIf;
	import spritePkg::*;

	// Sprite takes fetched data on this line
	spriteMaskT active;

	// Sprite is inside its display window
	spriteMaskT shift;

	// This pixel tick advances the sprite shift register
	// Always a subset of shift
	spriteMaskT clkShift;

	// Sprite uses two bits per pixel
	spriteMaskT multicolor;

	// The sequencer drives every control line
	modport seq (
		output active,
		output shift,
		output clkShift,
		output multicolor
	);

	// The shifter only listens
	modport shifter (
		input active,
		input shift,
		input clkShift,
		input multicolor
	);

endinterface

// ==== design/sprite_pkg.sv ====
`include "sprite_params.svh"

package spritePkg;

	// ================================================
	// Widths that carry a meaning
	// ================================================

	// One bit per sprite, bit n belongs to sprite n
	typedef logic [`SPRITE_COUNT-1:0] spriteMaskT;

	// Sprite number, sprite 0 has the highest priority
	typedef logic [2:0] spriteIdT;

	// Horizontal raster or sprite position
	typedef logic [`SPRITE_XW-1:0] xPosT;

	// Index into the 16 entry palette
	typedef logic [3:0] colorT;

	// Two bit sprite pixel code
	// Code 0 is always transparent
	typedef logic [1:0] pixelCodeT;

	// ================================================
	// Memory cycle kinds of the video bus
	// ================================================

	// Only a sprite cycle carries sprite data on db
	typedef enum logic [2:0] {
		VIC_IDLE    = 3'd0,
		VIC_CHAR    = 3'd1,
		VIC_GRAPH   = 3'd2,
		VIC_SPRITE  = 3'd3,
		VIC_REFRESH = 3'd4
	} vicCycleT;

endpackage

// ==== design/sprite_params.svh ====
`ifndef SPRITE_PARAMS_SVH
`define SPRITE_PARAMS_SVH

// Sprite engine dimensions
`define SPRITE_COUNT 8
`define SPRITE_BITS 24
`define SPRITE_XW 9

// ================================================
// Register port address map
// ================================================
// Addresses 0 to 7 hold the low byte of each sprite X position
`define SPRITE_REG_XMSB 4'd8
`define SPRITE_REG_ENABLE 4'd9
`define SPRITE_REG_EXPAND 4'd10
`define SPRITE_REG_MCMODE 4'd11
// Indexed color write, data bits 6 to 4 pick the sprite and bits 3 to 0 the color
`define SPRITE_REG_COLOR 4'd12
`define SPRITE_REG_MC0 4'd13
`define SPRITE_REG_MC1 4'd14

`endif
